// ==== csr_pkg.sv ====
// machine-mode csr definitions: widths, operation codes, addresses, reset values

package csr_pkg;

  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0]  reg_idx_t;

  // funct3 field of a csr instruction, codes 0 and 4 do nothing here
  typedef logic [2:0]  csr_op_t;

  localparam csr_op_t csr_rw  = 3'd1;
  localparam csr_op_t csr_rs  = 3'd2;
  localparam csr_op_t csr_rc  = 3'd3;
  localparam csr_op_t csr_rwi = 3'd5;
  localparam csr_op_t csr_rsi = 3'd6;
  localparam csr_op_t csr_rci = 3'd7;

  localparam csr_addr_t addr_mtvec    = 12'h305;
  localparam csr_addr_t addr_mscratch = 12'h340;
  localparam csr_addr_t addr_mepc     = 12'h341;
  localparam csr_addr_t addr_mcycle   = 12'hB00;
  localparam csr_addr_t addr_mhartid  = 12'hF14;

  localparam word_t mtvec_reset  = 32'h0000_0100;
  localparam word_t hartid_value = 32'h0000_0000;

  // does this access write its register at all
  function automatic logic csr_writes(input csr_op_t op, input reg_idx_t zimm);
    logic wr;
    case (op)
      csr_rw, csr_rwi: wr = 1'b1;
      // set and clear with x0 or a zero immediate are pure reads
      csr_rs, csr_rc, csr_rsi, csr_rci: wr = (zimm != '0);
      default: wr = 1'b0;
    endcase
    return wr;
  endfunction

  // value after the write, from the old contents and the operands
  function automatic word_t csr_new_value(input word_t old, input csr_op_t op,
                                          input reg_idx_t zimm, input word_t rs1_data);
    word_t imm;
    word_t nv;
    imm = word_t'(zimm);
    case (op)
      csr_rw:  nv = rs1_data;
      csr_rs:  nv = old | rs1_data;
      csr_rc:  nv = old & ~rs1_data;
      csr_rwi: nv = imm;
      csr_rsi: nv = old | imm;
      csr_rci: nv = old & ~imm;
      default: nv = old;
    endcase
    return nv;
  endfunction

endpackage

// ==== csr_access_if.sv ====
// csr access bundle, carries one instruction access per cycle to the registers
`timescale 1ns/1ps

interface csr_access_if;

  logic               enable;
  csr_pkg::csr_addr_t addr;
  csr_pkg::csr_op_t   op;
  // rs1 field, doubles as the zero-extended immediate
  csr_pkg::reg_idx_t  zimm;
  csr_pkg::word_t     rs1_data;

  // driving side, the csr file
  modport file (
    output enable,
    output addr,
    output op,
    output zimm,
    output rs1_data
  );

  // every register only listens
  modport register (
    input enable,
    input addr,
    input op,
    input zimm,
    input rs1_data
  );

endinterface

// ==== csr_reg.sv ====
// generic csr with address match, operation decode and an external write port
`timescale 1ns/1ps

module csr_reg #(
  parameter csr_pkg::csr_addr_t Addr       = '0,
  parameter csr_pkg::word_t     ResetValue = '0,
  parameter bit                 Writable   = 1'b1
) (
  input  logic                  clk,
  input  logic                  reset,
  csr_access_if.register        acc,
  input  logic                  ext_write,
  input  csr_pkg::word_t        ext_data,
  output csr_pkg::word_t        rd
);

  csr_pkg::word_t data;
  csr_pkg::word_t sw_value;
  logic           hit;
  logic           sw_write;

  // address decode, reads do not depend on enable
  assign hit = (acc.addr == Addr);

  // software write only when addressed, enabled and not a pure read
  always_comb begin
    sw_write = 1'b0;
    if (Writable && acc.enable && hit) begin
      sw_write = csr_pkg::csr_writes(acc.op, acc.zimm);
    end
  end

  assign sw_value = csr_pkg::csr_new_value(data, acc.op, acc.zimm, acc.rs1_data);

  always_ff @(posedge clk) begin
    if (reset) begin
      data <= ResetValue;
    end else if (ext_write) begin
      // hardware side effect, e.g. trap entry, beats software
      data <= ext_data;
    end else if (sw_write) begin
      data <= sw_value;
    end
  end

  // old contents when addressed, zero otherwise so the file can OR them
  assign rd = hit ? data : '0;

endmodule

// ==== csr_counter.sv ====
// mcycle csr, free-running cycle counter that software may overwrite
`timescale 1ns/1ps

module csr_counter #(
  parameter csr_pkg::csr_addr_t Addr = csr_pkg::addr_mcycle
) (
  input  logic           clk,
  input  logic           reset,
  csr_access_if.register acc,
  output csr_pkg::word_t rd
);

  csr_pkg::word_t count;
  csr_pkg::word_t sw_value;
  logic           hit;
  logic           sw_write;

  assign hit = (acc.addr == Addr);

  always_comb begin
    sw_write = 1'b0;
    if (acc.enable && hit) begin
      sw_write = csr_pkg::csr_writes(acc.op, acc.zimm);
    end
  end

  // set and clear act on the count seen this cycle
  assign sw_value = csr_pkg::csr_new_value(count, acc.op, acc.zimm, acc.rs1_data);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (sw_write) begin
      // written value replaces this cycle's increment
      count <= sw_value;
    end else begin
      // wraps to zero past the top
      count <= count + 32'd1;
    end
  end

  assign rd = hit ? count : '0;

endmodule

// ==== csr_file.sv ====
// machine-mode csr file, joins the registers, merges read data, flags illegal accesses
`timescale 1ns/1ps

module csr_file (
  input  logic               clk,
  input  logic               reset,
  input  logic               csr_enable,
  input  csr_pkg::csr_addr_t csr_addr,
  input  csr_pkg::csr_op_t   csr_op,
  input  csr_pkg::reg_idx_t  csr_zimm,
  input  csr_pkg::word_t     rs1_data,
  input  logic               trap,
  input  csr_pkg::word_t     trap_pc,
  output csr_pkg::word_t     rd_data,
  output logic               illegal
);

  csr_pkg::word_t rd_mtvec;
  csr_pkg::word_t rd_mscratch;
  csr_pkg::word_t rd_mepc;
  csr_pkg::word_t rd_mcycle;
  csr_pkg::word_t rd_mhartid;
  logic           mapped;
  logic           hartid_write;

  csr_access_if acc ();

  assign acc.enable   = csr_enable;
  assign acc.addr     = csr_addr;
  assign acc.op       = csr_op;
  assign acc.zimm     = csr_zimm;
  assign acc.rs1_data = rs1_data;

  csr_reg #(
    .Addr       (csr_pkg::addr_mtvec),
    .ResetValue (csr_pkg::mtvec_reset),
    .Writable   (1'b1)
  ) mtvec_inst (
    .clk       (clk),
    .reset     (reset),
    .acc       (acc),
    .ext_write (1'b0),
    .ext_data  (trap_pc),
    .rd        (rd_mtvec)
  );

  csr_reg #(
    .Addr       (csr_pkg::addr_mscratch),
    .ResetValue ('0),
    .Writable   (1'b1)
  ) mscratch_inst (
    .clk       (clk),
    .reset     (reset),
    .acc       (acc),
    .ext_write (1'b0),
    .ext_data  (trap_pc),
    .rd        (rd_mscratch)
  );

  // trap entry saves the faulting pc
  csr_reg #(
    .Addr       (csr_pkg::addr_mepc),
    .ResetValue ('0),
    .Writable   (1'b1)
  ) mepc_inst (
    .clk       (clk),
    .reset     (reset),
    .acc       (acc),
    .ext_write (trap),
    .ext_data  (trap_pc),
    .rd        (rd_mepc)
  );

  // read-only hart id
  csr_reg #(
    .Addr       (csr_pkg::addr_mhartid),
    .ResetValue (csr_pkg::hartid_value),
    .Writable   (1'b0)
  ) mhartid_inst (
    .clk       (clk),
    .reset     (reset),
    .acc       (acc),
    .ext_write (1'b0),
    .ext_data  (trap_pc),
    .rd        (rd_mhartid)
  );

  csr_counter #(
    .Addr (csr_pkg::addr_mcycle)
  ) mcycle_inst (
    .clk   (clk),
    .reset (reset),
    .acc   (acc),
    .rd    (rd_mcycle)
  );

  // at most one register is addressed, the rest return zero
  assign rd_data = rd_mtvec | rd_mscratch | rd_mepc | rd_mcycle | rd_mhartid;

  always_comb begin
    case (csr_addr)
      csr_pkg::addr_mtvec,
      csr_pkg::addr_mscratch,
      csr_pkg::addr_mepc,
      csr_pkg::addr_mcycle,
      csr_pkg::addr_mhartid: mapped = 1'b1;
      default:               mapped = 1'b0;
    endcase
  end

  // a set or clear with zero zimm on mhartid is a legal read
  assign hartid_write = (csr_addr == csr_pkg::addr_mhartid) &&
                        csr_pkg::csr_writes(csr_op, csr_zimm);

  assign illegal = csr_enable && (!mapped || hartid_write);

endmodule

// ==== csr_file_props.sv ====
// assertions on the csr file outputs for the illegal flag, unmapped reads and the hart id
`timescale 1ns/1ps

module csr_file_props (
  input logic               clk,
  input logic               reset,
  input logic               csr_enable,
  input csr_pkg::csr_addr_t csr_addr,
  input csr_pkg::word_t     rd_data,
  input logic               illegal
);

  logic mapped;
  // number of failed assertions for the testbench to watch
  int   failure_count = 0;

  assign mapped = (csr_addr == csr_pkg::addr_mtvec) || (csr_addr == csr_pkg::addr_mscratch) ||
                  (csr_addr == csr_pkg::addr_mepc) || (csr_addr == csr_pkg::addr_mcycle) ||
                  (csr_addr == csr_pkg::addr_mhartid);

  no_illegal_when_idle: assert property (
    @(posedge clk) disable iff (reset) !csr_enable |-> !illegal
  ) else begin
    $error("illegal is high while no access is enabled");
    failure_count++;
  end

  unmapped_reads_zero: assert property (
    @(posedge clk) disable iff (reset) !mapped |-> (rd_data == '0)
  ) else begin
    $error("nonzero read data from an unmapped address");
    failure_count++;
  end

  // any read of mhartid returns the fixed hart id
  hartid_constant: assert property (
    @(posedge clk) disable iff (reset)
      (csr_addr == csr_pkg::addr_mhartid) |-> (rd_data == csr_pkg::hartid_value)
  ) else begin
    $error("mhartid read a value other than the hart id");
    failure_count++;
  end

endmodule

bind csr_file csr_file_props props_inst (
  .clk        (clk),
  .reset      (reset),
  .csr_enable (csr_enable),
  .csr_addr   (csr_addr),
  .rd_data    (rd_data),
  .illegal    (illegal)
);

// ==== tb_csr_file.sv ====
// testbench for the csr file with directed and random accesses against a reference model
`timescale 1ns/1ps

module tb_csr_file;

  localparam int random_cycles = 1000;
  // twice the random run also covers the few dozen directed cycles
  localparam int max_cycles = 2 * random_cycles;

  logic               clk;
  logic               reset;
  logic               csr_enable;
  csr_pkg::csr_addr_t csr_addr;
  csr_pkg::csr_op_t   csr_op;
  csr_pkg::reg_idx_t  csr_zimm;
  csr_pkg::word_t     rs1_data;
  logic               trap;
  csr_pkg::word_t     trap_pc;
  csr_pkg::word_t     rd_data;
  logic               illegal;

  // expected register contents apart from the constant mhartid
  csr_pkg::word_t exp_mtvec;
  csr_pkg::word_t exp_mscratch;
  csr_pkg::word_t exp_mepc;
  csr_pkg::word_t exp_mcycle;

  integer seed = 20919;
  int     cycle_count = 0;

  csr_file csr_file_inst (
    .clk        (clk),
    .reset      (reset),
    .csr_enable (csr_enable),
    .csr_addr   (csr_addr),
    .csr_op     (csr_op),
    .csr_zimm   (csr_zimm),
    .rs1_data   (rs1_data),
    .trap       (trap),
    .trap_pc    (trap_pc),
    .rd_data    (rd_data),
    .illegal    (illegal)
  );

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "stopping at the first error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      fail_run($sformatf("Timeout: the tests did not finish within %0d cycles", max_cycles));
    end
  end

  // any failed assertion in the bound checker ends the run
  always @(csr_file_inst.props_inst.failure_count) begin
    if (csr_file_inst.props_inst.failure_count != 0) begin
      fail_run("A bound assertion on the csr file failed");
    end
  end

  task automatic check_value(input string name, input csr_pkg::word_t expected,
                             input csr_pkg::word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  function automatic logic is_mapped(input csr_pkg::csr_addr_t addr);
    return (addr == csr_pkg::addr_mtvec) || (addr == csr_pkg::addr_mscratch) ||
           (addr == csr_pkg::addr_mepc) || (addr == csr_pkg::addr_mcycle) ||
           (addr == csr_pkg::addr_mhartid);
  endfunction

  function automatic csr_pkg::word_t model_read(input csr_pkg::csr_addr_t addr);
    csr_pkg::word_t v;
    case (addr)
      csr_pkg::addr_mtvec:    v = exp_mtvec;
      csr_pkg::addr_mscratch: v = exp_mscratch;
      csr_pkg::addr_mepc:     v = exp_mepc;
      csr_pkg::addr_mcycle:   v = exp_mcycle;
      csr_pkg::addr_mhartid:  v = csr_pkg::hartid_value;
      default:                v = '0;
    endcase
    return v;
  endfunction

  // rw forms always write but set and clear need a nonzero rs1 field
  function automatic logic writes_register(input csr_pkg::csr_op_t op,
                                           input csr_pkg::reg_idx_t zimm);
    logic w;
    w = 1'b0;
    if (op == csr_pkg::csr_rw || op == csr_pkg::csr_rwi) begin
      w = 1'b1;
    end else if (op[1:0] != 2'b00) begin
      w = (zimm != 5'd0);
    end
    return w;
  endfunction

  function automatic csr_pkg::word_t op_result(input csr_pkg::word_t old,
                                               input csr_pkg::csr_op_t op,
                                               input csr_pkg::reg_idx_t zimm,
                                               input csr_pkg::word_t data);
    csr_pkg::word_t operand;
    csr_pkg::word_t v;
    // bit 2 of funct3 picks the immediate
    operand = op[2] ? {27'd0, zimm} : data;
    case (op[1:0])
      2'b01:   v = operand;
      2'b10:   v = old | operand;
      2'b11:   v = old & ~operand;
      default: v = old;
    endcase
    return v;
  endfunction

  // one access cycle that starts 1 ns past the rising edge
  task automatic do_access(input string name, input logic en, input csr_pkg::csr_addr_t addr,
                           input csr_pkg::csr_op_t op, input csr_pkg::reg_idx_t zimm,
                           input csr_pkg::word_t data, input logic trp,
                           input csr_pkg::word_t pc);
    csr_pkg::word_t exp_rd;
    csr_pkg::word_t new_value;
    logic           exp_illegal;
    logic           sw_write;
    csr_enable = en;
    csr_addr   = addr;
    csr_op     = op;
    csr_zimm   = zimm;
    rs1_data   = data;
    trap       = trp;
    trap_pc    = pc;
    @(negedge clk);
    exp_rd      = model_read(addr);
    sw_write    = en && writes_register(op, zimm);
    exp_illegal = en && (!is_mapped(addr) || (addr == csr_pkg::addr_mhartid && sw_write));
    check_value({name, " rd_data"}, exp_rd, rd_data);
    check_value({name, " illegal"}, csr_pkg::word_t'(exp_illegal), csr_pkg::word_t'(illegal));
    new_value = op_result(exp_rd, op, zimm, data);
    @(posedge clk);
    exp_mcycle = exp_mcycle + 32'd1;
    if (sw_write) begin
      case (addr)
        csr_pkg::addr_mtvec:    exp_mtvec = new_value;
        csr_pkg::addr_mscratch: exp_mscratch = new_value;
        csr_pkg::addr_mepc:     exp_mepc = new_value;
        csr_pkg::addr_mcycle:   exp_mcycle = new_value;
        default:                ;
      endcase
    end
    // trap entry wins over software
    if (trp) begin
      exp_mepc = pc;
    end
    #1;
  endtask

  task automatic read_all(input string name);
    do_access({name, " mcycle"}, 1'b1, csr_pkg::addr_mcycle, csr_pkg::csr_rs, 5'd0, '1, 0, '0);
    do_access({name, " mtvec"}, 1'b1, csr_pkg::addr_mtvec, csr_pkg::csr_rs, 5'd0, '1, 0, '0);
    do_access({name, " mscratch"}, 1'b1, csr_pkg::addr_mscratch, csr_pkg::csr_rc, 5'd0, '1,
              0, '0);
    do_access({name, " mepc"}, 1'b1, csr_pkg::addr_mepc, csr_pkg::csr_rsi, 5'd0, '0, 0, '0);
    do_access({name, " mhartid"}, 1'b1, csr_pkg::addr_mhartid, csr_pkg::csr_rs, 5'd0, '1,
              0, '0);
  endtask

  task automatic random_access(input int idx);
    csr_pkg::csr_addr_t addr;
    csr_pkg::reg_idx_t  zimm;
    logic               en;
    logic               trp;
    case ($unsigned($random(seed)) % 6)
      0:       addr = csr_pkg::addr_mtvec;
      1:       addr = csr_pkg::addr_mscratch;
      2:       addr = csr_pkg::addr_mepc;
      3:       addr = csr_pkg::addr_mcycle;
      4:       addr = csr_pkg::addr_mhartid;
      default: addr = csr_pkg::csr_addr_t'($random(seed));
    endcase
    // zero rs1 field in about a third of the accesses
    if ($unsigned($random(seed)) % 3 == 0) begin
      zimm = 5'd0;
    end else begin
      zimm = csr_pkg::reg_idx_t'($random(seed));
    end
    en  = ($unsigned($random(seed)) % 8) != 0;
    trp = ($unsigned($random(seed)) % 8) == 0;
    do_access($sformatf("random access %0d", idx), en, addr,
              csr_pkg::csr_op_t'($random(seed)), zimm, $random(seed), trp, $random(seed));
  endtask

  initial begin
    reset      = 1'b1;
    csr_enable = 1'b0;
    csr_addr   = '0;
    csr_op     = '0;
    csr_zimm   = '0;
    rs1_data   = '0;
    trap       = 1'b0;
    trap_pc    = '0;
    repeat (3) @(posedge clk);
    #1;
    reset        = 1'b0;
    exp_mtvec    = csr_pkg::mtvec_reset;
    exp_mscratch = '0;
    exp_mepc     = '0;
    exp_mcycle   = '0;

    // reset values with mcycle first so it still reads zero
    read_all("after reset");
    do_access("idle", 1'b0, csr_pkg::addr_mhartid, csr_pkg::csr_rw, 5'd3, '1, 0, '0);

    // counting while idle and then overwrite and wrap
    repeat (4) begin
      do_access("mcycle count", 1'b1, csr_pkg::addr_mcycle, csr_pkg::csr_rs, 5'd0, '0, 0, '0);
    end
    do_access("mcycle write", 1'b1, csr_pkg::addr_mcycle, csr_pkg::csr_rw, 5'd4,
              32'hFFFF_FFFE, 0, '0);
    repeat (3) begin
      do_access("mcycle wrap", 1'b1, csr_pkg::addr_mcycle, csr_pkg::csr_rs, 5'd0, '0, 0, '0);
    end
    do_access("mcycle clear", 1'b1, csr_pkg::addr_mcycle, csr_pkg::csr_rci, 5'd1, '0, 0, '0);

    // trap against a software write to mepc
    do_access("trap and write", 1'b1, csr_pkg::addr_mepc, csr_pkg::csr_rw, 5'd2,
              32'hAAAA_0000, 1, 32'h0000_2468);
    do_access("trap result", 1'b1, csr_pkg::addr_mepc, csr_pkg::csr_rs, 5'd0, '0, 0, '0);
    do_access("trap only", 1'b1, csr_pkg::addr_mscratch, csr_pkg::csr_rwi, 5'd9, '0,
              1, 32'h8000_0040);

    // illegal accesses leave everything alone
    do_access("unmapped write", 1'b1, 12'h123, csr_pkg::csr_rw, 5'd1, 32'h1234_5678, 0, '0);
    do_access("hartid rw", 1'b1, csr_pkg::addr_mhartid, csr_pkg::csr_rw, 5'd1, '1, 0, '0);
    do_access("hartid rwi", 1'b1, csr_pkg::addr_mhartid, csr_pkg::csr_rwi, 5'd0, '0, 0, '0);
    do_access("hartid rci", 1'b1, csr_pkg::addr_mhartid, csr_pkg::csr_rci, 5'd7, '0, 0, '0);
    do_access("hartid read", 1'b1, csr_pkg::addr_mhartid, csr_pkg::csr_rs, 5'd0, '1, 0, '0);
    read_all("after illegal");

    for (int i = 0; i < random_cycles; i++) begin
      random_access(i);
    end
    read_all("final");

    $display("Regression passed");
    $finish;
  end

endmodule

// ==== tb.f ====
csr_pkg.sv
csr_access_if.sv
csr_reg.sv
csr_counter.sv
csr_file.sv
csr_file_props.sv
tb_csr_file.sv

// ==== Bender.yml ====
package:
  name: csr_file

sources:
  - files:
      - csr_pkg.sv
      - csr_access_if.sv
      - csr_reg.sv
      - csr_counter.sv
      - csr_file.sv
  - target: test
    files:
      - csr_file_props.sv
      - tb_csr_file.sv
